//--- sources.f
+incdir+.
rob_pkg.sv
arch_regfile.sv
issue_stage.sv
reorder_buffer.sv
commit_stage.sv
rob_top.sv
rob_props.sv
rob_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module rob_tb -o rob_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/rob_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

//--- rob_tb.sv
`include "rob_params.svh"

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rob_pkg::*;

    typedef struct packed {
        instr_class_t           cls;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       pc;
        logic                   pred_taken;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } row_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      data;
    } store_exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_en;
    issue_req_t             in_req;
    logic                   ex_en;
    exec_result_t           ex_res;
    logic [`REG_ADDR_W-1:0] rf_raddr;
    logic                   stall;
    logic                   tag_en;
    logic [`ROB_TAG_W-1:0]  tag;
    commit_out_t            cmt;
    logic [`XLEN-1:0]       rf_rdata;

    row_t                  rows[$];
    int                    test_start[$];
    string                 test_name[$];
    logic [`XLEN-1:0]      model_rf [32];
    store_exp_t            exp_stores[$];
    logic [`ROB_TAG_W-1:0] tags[$];
    logic [`XLEN-1:0]      exp_redirect;
    int                    flush_expected;
    int                    flush_seen;
    bit                    stall_seen;
    int                    errors;
    int                    test_errors;
    int                    passed;
    int                    failed;

    rob_top dut0 (
        .clk(clk), .rst_n(rst_n), .in_en(in_en), .in_req(in_req), .ex_en(ex_en),
        .ex_res(ex_res), .rf_raddr(rf_raddr), .stall(stall), .tag_en(tag_en), .tag(tag),
        .cmt(cmt), .rf_rdata(rf_rdata)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(string name, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
        $display("error: %s = %h, expected %h", name, got, exp);
        test_errors++;
        errors++;
    endtask

    task automatic report_failure(string msg);
        $display("failure: %s", msg);
        test_errors++;
        errors++;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // commit side outputs, checked as they show up
    always @(negedge clk) begin
        store_exp_t e;
        if (rst_n) begin
            if (tag_en) begin
                tags.push_back(tag);
            end
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (cmt.store_en) begin
                if (exp_stores.size() == 0) begin
                    report_failure("store released that should not commit");
                end else begin
                    e = exp_stores.pop_front();
                    if (cmt.store_tag !== e.tag) begin
                        report_mismatch("cmt.store_tag", `XLEN'(cmt.store_tag), `XLEN'(e.tag));
                    end
                    if (cmt.store_data !== e.data) begin
                        report_mismatch("cmt.store_data", cmt.store_data, e.data);
                    end
                end
            end
            if (cmt.flush) begin
                flush_seen++;
                if (flush_seen > flush_expected) begin
                    report_failure("flush raised without a misprediction");
                end else if (cmt.redirect_pc !== exp_redirect) begin
                    report_mismatch("cmt.redirect_pc", cmt.redirect_pc, exp_redirect);
                end
            end
        end
    end

    task automatic add_row(instr_class_t cls, logic [`REG_ADDR_W-1:0] rd, logic [`XLEN-1:0] pc,
                           logic pred, logic [`XLEN-1:0] data, logic taken,
                           logic [`XLEN-1:0] target);
        row_t r;
        r = '{cls, rd, pc, pred, data, taken, target};
        rows.push_back(r);
    endtask

    task automatic begin_test(string name);
        test_start.push_back(rows.size());
        test_name.push_back(name);
    endtask

    task automatic build_table();
        begin_test("out of order alu");
        add_row(cls_alu, 5'd1, 32'h100, 1'b0, 32'h1111_0001, 1'b0, '0);
        add_row(cls_alu, 5'd2, 32'h104, 1'b0, 32'h2222_0002, 1'b0, '0);
        add_row(cls_alu, 5'd3, 32'h108, 1'b0, 32'h3333_0003, 1'b0, '0);
        add_row(cls_alu, 5'd1, 32'h10c, 1'b0, 32'h1111_0004, 1'b0, '0);
        add_row(cls_alu, 5'd0, 32'h110, 1'b0, 32'hdead_0005, 1'b0, '0);
        add_row(cls_alu, 5'd4, 32'h114, 1'b0, 32'h4444_0006, 1'b0, '0);
        add_row(cls_alu, 5'd2, 32'h118, 1'b0, 32'h2222_0007, 1'b0, '0);
        add_row(cls_alu, 5'd5, 32'h11c, 1'b0, 32'h5555_0008, 1'b0, '0);
        begin_test("stores");
        add_row(cls_alu, 5'd6, 32'h200, 1'b0, 32'h6666_0001, 1'b0, '0);
        add_row(cls_store, 5'd7, 32'h204, 1'b0, 32'haaaa_0002, 1'b0, '0);
        add_row(cls_store, 5'd0, 32'h208, 1'b0, 32'hbbbb_0003, 1'b0, '0);
        add_row(cls_alu, 5'd7, 32'h20c, 1'b0, 32'h7777_0004, 1'b0, '0);
        add_row(cls_store, 5'd6, 32'h210, 1'b0, 32'hcccc_0005, 1'b0, '0);
        begin_test("predicted control");
        add_row(cls_branch, 5'd0, 32'h300, 1'b0, '0, 1'b0, 32'h900);
        add_row(cls_branch, 5'd0, 32'h304, 1'b1, '0, 1'b1, 32'h800);
        add_row(cls_jump, 5'd8, 32'h308, 1'b0, 32'h0000_030c, 1'b1, 32'ha00);
        add_row(cls_alu, 5'd9, 32'h30c, 1'b0, 32'h9999_0004, 1'b0, '0);
        begin_test("mispredict taken");
        add_row(cls_alu, 5'd10, 32'h400, 1'b0, 32'haaaa_1001, 1'b0, '0);
        add_row(cls_branch, 5'd0, 32'h404, 1'b0, '0, 1'b1, 32'h2000);
        add_row(cls_alu, 5'd11, 32'h408, 1'b0, 32'hbad0_0003, 1'b0, '0);
        add_row(cls_store, 5'd0, 32'h40c, 1'b0, 32'hbad0_0004, 1'b0, '0);
        add_row(cls_alu, 5'd10, 32'h410, 1'b0, 32'hbad0_0005, 1'b0, '0);
        begin_test("mispredict not taken");
        add_row(cls_alu, 5'd12, 32'h500, 1'b0, 32'hcccc_1001, 1'b0, '0);
        add_row(cls_store, 5'd0, 32'h504, 1'b0, 32'h5707_0002, 1'b0, '0);
        add_row(cls_branch, 5'd0, 32'h508, 1'b1, '0, 1'b0, 32'h3000);
        add_row(cls_alu, 5'd12, 32'h50c, 1'b0, 32'hbad1_0004, 1'b0, '0);
        add_row(cls_store, 5'd0, 32'h510, 1'b0, 32'hbad1_0005, 1'b0, '0);
        begin_test("issue after flush");
        add_row(cls_alu, 5'd13, 32'h2000, 1'b0, 32'hdddd_0001, 1'b0, '0);
        add_row(cls_store, 5'd0, 32'h2004, 1'b0, 32'h5707_0003, 1'b0, '0);
        add_row(cls_alu, 5'd0, 32'h2008, 1'b0, 32'hffff_ffff, 1'b0, '0);
        begin_test("stall and drain");
        for (int i = 0; i < 20; i++) begin
            add_row(cls_alu, `REG_ADDR_W'($urandom_range(31, 0)), 32'h3000 + 32'(4 * i),
                    1'b0, $urandom(), 1'b0, '0);
        end
        test_start.push_back(rows.size());
    endtask

    task automatic issue_batch(input int first, input int last, output int next);
        int i;
        i = first;
        tags.delete();
        while (i < last && !stall) begin
            in_en             = 1'b1;
            in_req.cls        = rows[i].cls;
            in_req.rd         = rows[i].rd;
            in_req.pc         = rows[i].pc;
            in_req.pred_taken = rows[i].pred_taken;
            i++;
            step();
        end
        in_en = 1'b0;
        next  = i;
        // an empty buffer takes ROB_DEPTH - 1 entries before stall
        if (stall && (i - first) != `ROB_DEPTH - 1) begin
            report_mismatch("rows issued before stall", `XLEN'(i - first),
                            `XLEN'(`ROB_DEPTH - 1));
        end
        while (tags.size() < i - first) begin
            @(negedge clk);
        end
        step();
        for (int a = 0; a < tags.size(); a++) begin
            for (int b = a + 1; b < tags.size(); b++) begin
                if (tags[a] == tags[b]) begin
                    report_failure($sformatf("tag %h handed out twice", tags[a]));
                end
            end
        end
    endtask

    // program order walk, stops at the first mispredicted control row
    task automatic model_batch(input int first, input int n, output bit stop);
        row_t       r;
        store_exp_t e;
        logic       pred;
        stop = 1'b0;
        for (int k = 0; k < n && !stop; k++) begin
            r = rows[first + k];
            if ((r.cls == cls_alu || r.cls == cls_jump) && r.rd != '0) begin
                model_rf[r.rd] = r.data;
            end
            if (r.cls == cls_store) begin
                e.tag  = tags[k];
                e.data = r.data;
                exp_stores.push_back(e);
            end
            pred = r.pred_taken | (r.cls == cls_jump);
            if ((r.cls == cls_branch || r.cls == cls_jump) && r.taken != pred) begin
                flush_expected++;
                exp_redirect = r.taken ? r.target : r.pc + `XLEN'(4);
                stop = 1'b1;
            end
        end
    endtask

    task automatic complete_batch(input int first);
        int order[$];
        int pick;
        int tmp;
        for (int j = 0; j < tags.size(); j++) begin
            order.push_back(j);
        end
        for (int j = order.size() - 1; j > 0; j--) begin
            pick        = int'($urandom_range(j, 0));
            tmp         = order[j];
            order[j]    = order[pick];
            order[pick] = tmp;
        end
        foreach (order[j]) begin
            ex_en         = 1'b1;
            ex_res.tag    = tags[order[j]];
            ex_res.data   = rows[first + order[j]].data;
            ex_res.taken  = rows[first + order[j]].taken;
            ex_res.target = rows[first + order[j]].target;
            step();
            ex_en = 1'b0;
            repeat ($urandom_range(2, 0)) step();
        end
    endtask

    task automatic drain();
        while (exp_stores.size() != 0 || flush_seen < flush_expected) begin
            @(negedge clk);
        end
        // at most one retire per cycle
        repeat (`ROB_DEPTH + 2) step();
    endtask

    task automatic check_regs();
        logic [`REG_ADDR_W-1:0] a;
        for (int r = 0; r < 32; r++) begin
            a        = `REG_ADDR_W'(r);
            rf_raddr = a;
            @(negedge clk);
            if (rf_rdata !== model_rf[a]) begin
                report_mismatch($sformatf("rf_rdata[x%0d]", r), rf_rdata, model_rf[a]);
            end
            step();
        end
    endtask

    task automatic close_test(string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %-22s ok", name);
        end else begin
            failed++;
            $display("test %-22s %0d errors", name, test_errors);
        end
    endtask

    task automatic run_test(input int t);
        int first;
        int last;
        int next;
        bit stop;
        bit exp_stall;
        first          = test_start[t];
        last           = test_start[t + 1];
        exp_stall      = (last - first) >= `ROB_DEPTH - 1;
        test_errors    = 0;
        flush_expected = 0;
        flush_seen     = 0;
        stall_seen     = 1'b0;
        stop           = 1'b0;
        while (first < last && !stop) begin
            issue_batch(first, last, next);
            model_batch(first, next - first, stop);
            complete_batch(first);
            drain();
            first = next;
        end
        if (stall_seen != exp_stall) begin
            report_failure($sformatf("stall seen %0d, expected %0d", stall_seen, exp_stall));
        end
        if (stall) begin
            report_failure("stall still high after the buffer drained");
        end
        if (flush_seen != flush_expected) begin
            report_mismatch("flush count", `XLEN'(flush_seen), `XLEN'(flush_expected));
        end
        check_regs();
        close_test(test_name[t]);
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * 4);
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("Testbench failed");
        $finish;
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_en    = 1'b0;
        in_req   = '0;
        ex_en    = 1'b0;
        ex_res   = '0;
        rf_raddr = '0;
        void'($urandom(32'h087c6108));
        foreach (model_rf[i]) begin
            model_rf[i] = '0;
        end
        build_table();
        fork
            watchdog(rows.size() * 40 + 3);
        join_none
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_errors = 0;
        if (stall !== 1'b0) report_mismatch("stall", `XLEN'(stall), '0);
        if (tag_en !== 1'b0) report_mismatch("tag_en", `XLEN'(tag_en), '0);
        if (cmt.store_en !== 1'b0) report_mismatch("cmt.store_en", `XLEN'(cmt.store_en), '0);
        if (cmt.flush !== 1'b0) report_mismatch("cmt.flush", `XLEN'(cmt.flush), '0);
        check_regs();
        close_test("reset state");
        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- rob_props.sv
`include "rob_params.svh"

module rob_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  dispatch_en,
    input logic                  rob_full,
    input logic                  head_ready,
    input logic                  flush,
    input logic [`ROB_DEPTH-1:0] occupied,
    input logic [`ROB_TAG_W:0]   count
);
    timeunit 1ns;
    timeprecision 100ps;

    full_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rob_full)
        else $error("rob_full high right after reset");

    // once full, the issue register stays empty
    no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        rob_full |=> !dispatch_en)
        else $error("dispatch after rob_full");

    // a ready head means the buffer holds at least one entry
    ready_head_occupied: assert property (@(posedge clk) disable iff (!rst_n)
        head_ready |-> (count != '0))
        else $error("head_ready with an empty buffer");

    empty_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (occupied == '0) && (count == '0))
        else $error("entries left after flush");

endmodule

bind reorder_buffer rob_props u_props (
    .clk(clk), .rst_n(rst_n), .dispatch_en(dispatch_en), .rob_full(rob_full),
    .head_ready(head_ready), .flush(flush), .occupied(occupied), .count(count)
);

//--- rob_top.sv
`include "rob_params.svh"

module rob_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_en,
    input  rob_pkg::issue_req_t    in_req,
    input  logic                   ex_en,
    input  rob_pkg::exec_result_t  ex_res,
    input  logic [`REG_ADDR_W-1:0] rf_raddr,
    output logic                   stall,
    output logic                   tag_en,
    output logic [`ROB_TAG_W-1:0]  tag,
    output rob_pkg::commit_out_t   cmt,
    output logic [`XLEN-1:0]       rf_rdata
);
    import rob_pkg::*;

    dispatch_t             disp;
    rob_entry_t            head;
    logic                  dispatch_en;
    logic                  rob_full;
    logic                  head_ready;
    logic                  retire;
    logic                  flush;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    logic [`ROB_TAG_W-1:0] head_tag;

    // allocated tag goes out with the dispatch
    assign tag_en = dispatch_en;
    assign tag    = disp.tag;

    issue_stage u_issue (
        .clk(clk), .rst_n(rst_n), .in_en(in_en), .in_req(in_req), .rob_full(rob_full),
        .alloc_tag(alloc_tag), .flush(flush), .stall(stall), .dispatch_en(dispatch_en),
        .disp(disp)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst_n(rst_n), .dispatch_en(dispatch_en), .disp(disp), .ex_en(ex_en),
        .ex_res(ex_res), .retire(retire), .flush(flush), .alloc_tag(alloc_tag),
        .rob_full(rob_full), .head_ready(head_ready), .head(head), .head_tag(head_tag)
    );

    commit_stage u_commit (
        .clk(clk), .rst_n(rst_n), .head_ready(head_ready), .head(head), .head_tag(head_tag),
        .retire(retire), .flush(flush), .cmt(cmt), .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
    );

endmodule

//--- commit_stage.sv
`include "rob_params.svh"

module commit_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   head_ready,
    input  rob_pkg::rob_entry_t    head,
    input  logic [`ROB_TAG_W-1:0]  head_tag,
    output logic                   retire,
    output logic                   flush,
    output rob_pkg::commit_out_t   cmt,
    input  logic [`REG_ADDR_W-1:0] rf_raddr,
    output logic [`XLEN-1:0]       rf_rdata
);

    logic                  mispredict;
    logic                  store_retire;
    logic                  rf_we;
    logic                  store_en_q;
    logic                  flush_q;
    logic [`ROB_TAG_W-1:0] store_tag_q;
    logic [`XLEN-1:0]      store_data_q;
    logic [`XLEN-1:0]      redirect_q;

    // nothing retires while the wrong path is being cleared
    assign retire       = head_ready & ~flush_q;
    assign store_retire = retire & head.is_store;
    assign mispredict   = retire & head.is_ctrl & (head.taken != head.pred_taken);
    assign rf_we        = retire & head.writes_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_en_q <= 1'b0;
            flush_q    <= 1'b0;
        end else begin
            store_en_q <= store_retire;
            flush_q    <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (store_retire) begin
            store_tag_q  <= head_tag;
            store_data_q <= head.data;
        end
        if (mispredict) begin
            // not taken falls through to the next instruction
            redirect_q <= head.taken ? head.target : head.pc + `XLEN'(4);
        end
    end

    assign flush           = flush_q;
    assign cmt.store_en    = store_en_q;
    assign cmt.store_tag   = store_tag_q;
    assign cmt.store_data  = store_data_q;
    assign cmt.flush       = flush_q;
    assign cmt.redirect_pc = redirect_q;

    arch_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_we),
        .waddr (head.rd),
        .wdata (head.data),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

//--- reorder_buffer.sv
`include "rob_params.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dispatch_en,
    input  rob_pkg::dispatch_t     disp,
    input  logic                   ex_en,
    input  rob_pkg::exec_result_t  ex_res,
    input  logic                   retire,
    input  logic                   flush,
    output logic [`ROB_TAG_W-1:0]  alloc_tag,
    output logic                   rob_full,
    output logic                   head_ready,
    output rob_pkg::rob_entry_t    head,
    output logic [`ROB_TAG_W-1:0]  head_tag
);
    import rob_pkg::*;

    localparam logic [`ROB_TAG_W:0]   FULL_MARK = (`ROB_TAG_W + 1)'(`ROB_DEPTH - 1);
    localparam logic [`ROB_TAG_W:0]   CNT_ONE   = (`ROB_TAG_W + 1)'(1);
    localparam logic [`ROB_TAG_W-1:0] PTR_ONE   = `ROB_TAG_W'(1);

    rob_entry_t            entries [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_TAG_W-1:0] head_ptr;
    logic [`ROB_TAG_W-1:0] tail_ptr;
    logic [`ROB_TAG_W:0]   count;
    logic [`ROB_TAG_W:0]   count_next;
    logic [`ROB_TAG_W:0]   count_pending;
    logic                  complete;

    // results for empty or already finished slots are dropped
    assign complete = ex_en & occupied[ex_res.tag] & ~done[ex_res.tag];

    always_comb begin
        count_next = count;
        if (dispatch_en) begin
            count_next = count_next + CNT_ONE;
        end
        if (retire) begin
            count_next = count_next - CNT_ONE;
        end
    end

    // the entry in the issue register has to fit as well
    assign count_pending = count + {`ROB_TAG_W'(0), dispatch_en};
    assign rob_full      = (count_pending >= FULL_MARK);

    assign alloc_tag  = tail_ptr;
    assign head_tag   = head_ptr;
    assign head       = entries[head_ptr];
    assign head_ready = occupied[head_ptr] & done[head_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // wrong path, drop everything in flight
            occupied <= '0;
            done     <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (dispatch_en) begin
                occupied[tail_ptr] <= 1'b1;
                done[tail_ptr]     <= 1'b0;
                tail_ptr           <= tail_ptr + PTR_ONE;
            end
            if (complete) begin
                done[ex_res.tag] <= 1'b1;
            end
            if (retire) begin
                occupied[head_ptr] <= 1'b0;
                done[head_ptr]     <= 1'b0;
                head_ptr           <= head_ptr + PTR_ONE;
            end
            count <= count_next;
        end
    end

    // entry payload
    // dispatch and completion never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        if (dispatch_en) begin
            entries[tail_ptr].rd         <= disp.rd;
            entries[tail_ptr].writes_rd  <= disp.writes_rd;
            entries[tail_ptr].is_store   <= disp.is_store;
            entries[tail_ptr].is_ctrl    <= disp.is_ctrl;
            entries[tail_ptr].pred_taken <= disp.pred_taken;
            entries[tail_ptr].pc         <= disp.pc;
        end
        if (complete) begin
            entries[ex_res.tag].data   <= ex_res.data;
            entries[ex_res.tag].taken  <= ex_res.taken;
            entries[ex_res.tag].target <= ex_res.target;
        end
    end

endmodule

//--- issue_stage.sv
`include "rob_params.svh"

module issue_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_en,
    input  rob_pkg::issue_req_t   in_req,
    input  logic                  rob_full,
    input  logic [`ROB_TAG_W-1:0] alloc_tag,
    input  logic                  flush,
    output logic                  stall,
    output logic                  dispatch_en,
    output rob_pkg::dispatch_t    disp
);
    import rob_pkg::*;

    issue_req_t req_q;
    logic       valid_q;
    logic       accept;
    logic       is_alu;
    logic       is_jump;

    // requests during stall or flush are dropped
    assign accept = in_en & ~rob_full & ~flush;
    assign stall  = rob_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= in_req;
        end
    end

    assign is_alu  = (req_q.cls == cls_alu);
    assign is_jump = (req_q.cls == cls_jump);

    // an instruction still held during a flush is younger, drop it
    assign dispatch_en = valid_q & ~flush;

    always_comb begin
        disp.tag        = alloc_tag;
        disp.rd         = req_q.rd;
        disp.writes_rd  = (is_alu | is_jump) & (req_q.rd != '0);
        disp.is_store   = (req_q.cls == cls_store);
        disp.is_ctrl    = (req_q.cls == cls_branch) | is_jump;
        // jumps always go
        disp.pred_taken = req_q.pred_taken | is_jump;
        disp.pc         = req_q.pc;
    end

endmodule

//--- arch_regfile.sv
`include "rob_params.svh"

module arch_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr,
    output logic [`XLEN-1:0]       rdata
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NUM_REGS];

    // architectural state starts from zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    always_comb begin
        if (raddr == '0) begin
            rdata = '0;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule

//--- rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef enum logic [1:0] {
        cls_alu,
        cls_branch,
        cls_jump,
        cls_store
    } instr_class_t;

    typedef struct packed {
        instr_class_t           cls;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       pc;
        logic                   pred_taken;
    } issue_req_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes_rd;
        logic                   is_store;
        logic                   is_ctrl;
        logic                   pred_taken;
        logic [`XLEN-1:0]       pc;
    } dispatch_t;

    typedef struct packed {
        logic [`ROB_TAG_W-1:0]  tag;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } exec_result_t;

    // dispatch fields without the tag, plus the result
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic                   writes_rd;
        logic                   is_store;
        logic                   is_ctrl;
        logic                   pred_taken;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       data;
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } rob_entry_t;

    typedef struct packed {
        logic                   store_en;
        logic [`ROB_TAG_W-1:0]  store_tag;
        logic [`XLEN-1:0]       store_data;
        logic                   flush;
        logic [`XLEN-1:0]       redirect_pc;
    } commit_out_t;

endpackage

//--- rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer geometry
// tag width has to stay log2 of the depth
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// datapath
`define XLEN 32

// architectural register address, 32 registers
`define REG_ADDR_W 5

`endif
